//--- common/pifwb_config.svh
`ifndef PIFWB_CONFIG_SVH
`define PIFWB_CONFIG_SVH

// ------------------------------
// primary I2C controller registers
// ------------------------------

// command register
`define PIF_I2C_CMDR    8'h41
// transmit data
`define PIF_I2C_TXDR    8'h44
// status
`define PIF_I2C_SR      8'h45
// receive data
`define PIF_I2C_RXDR    8'h47

// ------------------------------
// command bytes
// ------------------------------

// STA STO RD WR ACK CKSDIS rsvd rsvd
// clock stretch disabled while the controller is set up
`define PIF_CMD_CKSDIS  8'h04
// normal run with no command bits
`define PIF_CMD_RUN     8'h00

// ------------------------------
// received byte format
// ------------------------------

// payload sits below the two tag bits
`define PIF_DATA_BITS   6

// tag in bits 7:6
`define PIF_TAG_ADDR    2'b10
`define PIF_TAG_DATA    2'b01

// ------------------------------
// parallel register port
// ------------------------------

// register address is the low part of the payload
`define PIF_ADDR_W      4
// read sub-address counter width
`define PIF_SUBA_W      7

`endif

//--- common/pifwb_pkg.sv
package pifwb_pkg;

    `include "pifwb_config.svh"

    // ------------------------------
    // wishbone
    // ------------------------------

    // master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [7:0] adr;
        logic [7:0] dat;
    } wbReq_t;

    // slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wbRsp_t;

    // ------------------------------
    // decoded controller data
    // ------------------------------

    // SR layout is TIP BUSY RARC SRW ARBL TRRDY TROE HGC
    typedef struct packed {
        logic tip;
        logic busy;
        logic rarc;
        logic srw;
        logic trrdy;
        logic troe;
    } efbStatus_t;

    // one byte from RXDR split by its tag
    typedef struct packed {
        logic                      isAddr;
        logic                      isData;
        logic [`PIF_DATA_BITS-1:0] payload;
    } rxByte_t;

    // ------------------------------
    // port side
    // ------------------------------

    typedef struct packed {
        logic                      pWr;
        logic [`PIF_ADDR_W-1:0]    rwAddr;
        logic                      rdFinished;
        logic [`PIF_SUBA_W-1:0]    rdSubA;
        logic [`PIF_DATA_BITS-1:0] wrData;
    } pifPort_t;

    // sequencer events towards the port stage
    typedef struct packed {
        logic    rxVld;
        rxByte_t rxByte;
        logic    txDone;
    } seqEvent_t;

endpackage

//--- hdl/efbRespDecode.sv
`timescale 1ns/1ps

`include "pifwb_config.svh"

module efbRespDecode
    import pifwb_pkg::*;
(
    input  logic       xclk,
    input  logic       sys_rst,
    input  wbReq_t     wbReq_i,
    input  wbRsp_t     wbRsp_i,
    output logic       statusVld_o,
    output efbStatus_t status_o,
    output logic       rxVld_o,
    output rxByte_t    rxByte_o
);

    logic hitSr;
    logic hitRxdr;
    logic rdAck;

    // ------------------------------
    // address hits
    // ------------------------------

    // address is stable a cycle before strobe so the hit is ready by ack
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            hitSr   <= 1'b0;
            hitRxdr <= 1'b0;
        end else begin
            hitSr   <= (wbReq_i.adr == `PIF_I2C_SR);
            hitRxdr <= (wbReq_i.adr == `PIF_I2C_RXDR);
        end
    end

    // ------------------------------
    // read data decode
    // ------------------------------

    assign rdAck = wbRsp_i.ack & wbReq_i.cyc & wbReq_i.stb & ~wbReq_i.we;

    assign statusVld_o = rdAck & hitSr;
    assign rxVld_o     = rdAck & hitRxdr;

    // SR bit 3 (ARBL) and bit 0 (HGC) are not needed by a slave
    assign status_o.tip   = wbRsp_i.dat[7];
    assign status_o.busy  = wbRsp_i.dat[6];
    assign status_o.rarc  = wbRsp_i.dat[5];
    assign status_o.srw   = wbRsp_i.dat[4];
    assign status_o.trrdy = wbRsp_i.dat[2];
    assign status_o.troe  = wbRsp_i.dat[1];

    // tag on top, payload below
    assign rxByte_o.isAddr  = (wbRsp_i.dat[7:`PIF_DATA_BITS] == `PIF_TAG_ADDR);
    assign rxByte_o.isData  = (wbRsp_i.dat[7:`PIF_DATA_BITS] == `PIF_TAG_DATA);
    assign rxByte_o.payload = wbRsp_i.dat[`PIF_DATA_BITS-1:0];

endmodule

//--- wbSequencer/wbSequencer.sv
`timescale 1ns/1ps

`include "pifwb_config.svh"

module wbSequencer
    import pifwb_pkg::*;
(
    input  logic       xclk,
    input  logic       sys_rst,
    input  logic       statusVld_i,
    input  efbStatus_t status_i,
    input  logic       rxVld_i,
    input  rxByte_t    rxByte_i,
    input  logic [7:0] xo_i,
    input  logic       wbAck_i,
    output wbReq_t     wbReq_o,
    output seqEvent_t  event_o
);

    typedef enum logic [3:0] {
        sStart,
        sInit1,
        sInit2,
        sInit3,
        sInit4,
        sIdle,
        sIdleChk,
        sWaitTr,
        sRxDone,
        sTxDone,
        sWr,
        sRd
    } seqState_t;

    seqState_t state;
    seqState_t retState;

    // flags from the last status read
    logic busy;
    logic txReady;
    logic rxReady;
    logic lastNak;

    logic ackSeen;

    // ack only counts while our strobe is out
    assign ackSeen = wbAck_i & wbReq_o.cyc & wbReq_o.stb;

    // ------------------------------
    // status flags
    // ------------------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            busy    <= 1'b0;
            txReady <= 1'b0;
            rxReady <= 1'b0;
            lastNak <= 1'b0;
        end else if (statusVld_i) begin
            busy    <= status_i.busy;
            // master wants a byte and the shift register is free
            txReady <= status_i.busy & status_i.trrdy & status_i.srw & ~status_i.tip;
            // byte waiting in RXDR
            rxReady <= status_i.busy & status_i.trrdy & ~status_i.srw;
            lastNak <= status_i.busy & status_i.rarc;
        end
    end

    // ------------------------------
    // sequencer
    // ------------------------------

    // address and data go out one cycle ahead of cyc/stb
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            state    <= sStart;
            retState <= sStart;
            wbReq_o  <= '0;
            event_o  <= '0;
        end else begin
            event_o.rxVld  <= 1'b0;
            event_o.txDone <= 1'b0;

            case (state)
                // stop clock stretching during setup
                sStart: begin
                    wbReq_o.adr <= `PIF_I2C_CMDR;
                    wbReq_o.dat <= `PIF_CMD_CKSDIS;
                    retState    <= sInit1;
                    state       <= sWr;
                end
                sInit1: begin
                    wbReq_o.adr <= `PIF_I2C_SR;
                    wbReq_o.dat <= 8'h00;
                    retState    <= sInit2;
                    state       <= sRd;
                end
                // poll SR until the bus is quiet then flush RXDR
                sInit2: begin
                    if (!busy) begin
                        wbReq_o.adr <= `PIF_I2C_RXDR;
                        retState    <= sInit3;
                    end else begin
                        wbReq_o.adr <= `PIF_I2C_SR;
                        retState    <= sInit2;
                    end
                    state <= sRd;
                end
                // second dummy RXDR read
                sInit3: begin
                    wbReq_o.adr <= `PIF_I2C_RXDR;
                    retState    <= sInit4;
                    state       <= sRd;
                end
                sInit4: begin
                    wbReq_o.adr <= `PIF_I2C_CMDR;
                    wbReq_o.dat <= `PIF_CMD_RUN;
                    retState    <= sIdle;
                    state       <= sWr;
                end
                sIdle: begin
                    wbReq_o.adr <= `PIF_I2C_SR;
                    wbReq_o.dat <= 8'h00;
                    retState    <= sIdleChk;
                    state       <= sRd;
                end
                // once busy shows up read SR once more and decide
                sIdleChk: begin
                    wbReq_o.adr <= `PIF_I2C_SR;
                    retState    <= busy ? sWaitTr : sIdleChk;
                    state       <= sRd;
                end
                sWaitTr: begin
                    if (lastNak) begin
                        state <= sStart;
                    end else if (txReady) begin
                        wbReq_o.adr <= `PIF_I2C_TXDR;
                        wbReq_o.dat <= xo_i;
                        retState    <= sTxDone;
                        state       <= sWr;
                    end else if (rxReady) begin
                        wbReq_o.adr <= `PIF_I2C_RXDR;
                        retState    <= sRxDone;
                        state       <= sRd;
                    end else if (!busy) begin
                        // transaction gone without a byte
                        state <= sStart;
                    end else begin
                        wbReq_o.adr <= `PIF_I2C_SR;
                        retState    <= sWaitTr;
                        state       <= sRd;
                    end
                end
                sRxDone: state <= sIdle;
                sTxDone: state <= sIdle;
                // shared write cycle
                sWr: begin
                    if (ackSeen) begin
                        wbReq_o.cyc <= 1'b0;
                        wbReq_o.stb <= 1'b0;
                        wbReq_o.we  <= 1'b0;
                        state       <= retState;
                        if (retState == sTxDone) begin
                            event_o.txDone <= 1'b1;
                        end
                    end else begin
                        wbReq_o.cyc <= 1'b1;
                        wbReq_o.stb <= 1'b1;
                        wbReq_o.we  <= 1'b1;
                    end
                end
                // shared read cycle
                sRd: begin
                    if (ackSeen) begin
                        wbReq_o.cyc <= 1'b0;
                        wbReq_o.stb <= 1'b0;
                        state       <= retState;
                        // init flush reads are not reported
                        if (rxVld_i && retState == sRxDone) begin
                            event_o.rxVld  <= 1'b1;
                            event_o.rxByte <= rxByte_i;
                        end
                    end else begin
                        wbReq_o.cyc <= 1'b1;
                        wbReq_o.stb <= 1'b1;
                    end
                end
                default: state <= sStart;
            endcase
        end
    end

endmodule

//--- hdl/pifPortStage.sv
`timescale 1ns/1ps

`include "pifwb_config.svh"

module pifPortStage
    import pifwb_pkg::*;
(
    input  logic      xclk,
    input  logic      sys_rst,
    input  seqEvent_t event_i,
    output pifPort_t  pif_o
);

    // current register address and read pointer
    logic [`PIF_ADDR_W-1:0] rwAddr;
    logic [`PIF_SUBA_W-1:0] rdSubAddr;

    // first register stage of the port
    pifPort_t pifLoc;

    logic addrEvt;
    logic dataEvt;

    assign addrEvt = event_i.rxVld & event_i.rxByte.isAddr;
    assign dataEvt = event_i.rxVld & event_i.rxByte.isData;

    // ------------------------------
    // address tracking
    // ------------------------------

    // untagged bytes leave everything as it is
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            rwAddr    <= '0;
            rdSubAddr <= '0;
        end else if (addrEvt) begin
            rwAddr    <= event_i.rxByte.payload[`PIF_ADDR_W-1:0];
            rdSubAddr <= '0;
        end else if (event_i.txDone) begin
            // wraps at the counter width
            rdSubAddr <= rdSubAddr + 1'b1;
        end
    end

    // ------------------------------
    // local port value
    // ------------------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            pifLoc <= '0;
        end else begin
            pifLoc.pWr        <= dataEvt;
            pifLoc.rdFinished <= event_i.txDone;
            pifLoc.rwAddr     <= rwAddr;
            pifLoc.rdSubA     <= rdSubAddr;
            // data holds until the next data byte
            if (dataEvt) begin
                pifLoc.wrData <= event_i.rxByte.payload;
            end
        end
    end

    // ------------------------------
    // output register
    // ------------------------------

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            pif_o <= '0;
        end else begin
            pif_o <= pifLoc;
        end
    end

endmodule

//--- hdl/pifWbBridge.sv
`timescale 1ns/1ps

// I2C slave controller to parallel register port
module pifWbBridge
    import pifwb_pkg::*;
(
    input  logic       xclk,
    input  logic       sys_rst,
    input  wbRsp_t     wbRsp_i,
    input  logic [7:0] xo_i,
    output wbReq_t     wbReq_o,
    output pifPort_t   pif_o
);

    logic       statusVld;
    efbStatus_t status;
    logic       rxVld;
    rxByte_t    rxByte;
    seqEvent_t  seqEvent;

    // read data decode from the controller
    efbRespDecode efbRespDecode_i (
        .xclk        (xclk),
        .sys_rst     (sys_rst),
        .wbReq_i     (wbReq_o),
        .wbRsp_i     (wbRsp_i),
        .statusVld_o (statusVld),
        .status_o    (status),
        .rxVld_o     (rxVld),
        .rxByte_o    (rxByte)
    );

    // wishbone master
    wbSequencer wbSequencer_i (
        .xclk        (xclk),
        .sys_rst     (sys_rst),
        .statusVld_i (statusVld),
        .status_i    (status),
        .rxVld_i     (rxVld),
        .rxByte_i    (rxByte),
        .xo_i        (xo_i),
        .wbAck_i     (wbRsp_i.ack),
        .wbReq_o     (wbReq_o),
        .event_o     (seqEvent)
    );

    // register port outputs
    pifPortStage pifPortStage_i (
        .xclk    (xclk),
        .sys_rst (sys_rst),
        .event_i (seqEvent),
        .pif_o   (pif_o)
    );

endmodule

//--- dv/pifwb_checker.sv
`timescale 1ns/1ps

module pifwb_checker
    import pifwb_pkg::*;
(
    input logic     xclk,
    input logic     sys_rst,
    input wbReq_t   wbReq_i,
    input logic     wbAck_i,
    input pifPort_t pif_i
);

    // ------------------------------
    // wishbone master side
    // ------------------------------

    stbNeedsCyc: assert property (@(posedge xclk) disable iff (!sys_rst)
        wbReq_i.stb |-> wbReq_i.cyc)
        else $error("strobe high without cycle");

    // stalled transfer keeps address, data and controls
    holdOnStall: assert property (@(posedge xclk) disable iff (!sys_rst)
        (wbReq_i.cyc && wbReq_i.stb && !wbAck_i) |=> $stable(wbReq_i))
        else $error("request changed while the slave stalled");

    dropAfterAck: assert property (@(posedge xclk) disable iff (!sys_rst)
        (wbReq_i.cyc && wbReq_i.stb && wbAck_i) |=> !wbReq_i.cyc && !wbReq_i.stb)
        else $error("cycle still open after acknowledge");

    // port pulses
    wrOneCycle: assert property (@(posedge xclk) disable iff (!sys_rst)
        pif_i.pWr |=> !pif_i.pWr)
        else $error("write strobe longer than one cycle");

    rdFinOneCycle: assert property (@(posedge xclk) disable iff (!sys_rst)
        pif_i.rdFinished |=> !pif_i.rdFinished)
        else $error("read-finished longer than one cycle");

endmodule

bind pifWbBridge pifwb_checker pifwb_checker_i (
    .xclk    (xclk),
    .sys_rst (sys_rst),
    .wbReq_i (wbReq_o),
    .wbAck_i (wbRsp_i.ack),
    .pif_i   (pif_o)
);

//--- dv/pifwb_tb.sv
`timescale 1ns/1ps

`include "pifwb_config.svh"

module pifwb_tb
    import pifwb_pkg::*;
();

    // SR bits TIP BUSY RARC SRW ARBL TRRDY TROE HGC
    localparam logic [7:0] srIdle = 8'h00;
    localparam logic [7:0] srBusy = 8'h40;
    localparam logic [7:0] srTx   = 8'h54;
    localparam logic [7:0] srRx   = 8'h44;
    localparam logic [7:0] srNak  = 8'h60;
    localparam int drainLimit = 40000;

    logic       xclk;
    logic       sys_rst;
    wbRsp_t     wbRsp_i;
    logic [7:0] xo_i;
    wbReq_t     wbReq_o;
    pifPort_t   pif_o;

    // scripted controller answers and expected results
    wbReq_t      expXfer[$];
    string       xferName[$];
    int          stallQ[$];
    logic [7:0]  srQ[$];
    logic [7:0]  rxQ[$];
    logic [7:0]  xoQ[$];
    pifPort_t    expPif[$];
    string       pifName[$];
    pifPort_t    refState;
    logic [31:0] lcgState;
    logic        xferOpen;
    int          stallLeft;

    pifWbBridge pifWbBridge_i (
        .xclk    (xclk),
        .sys_rst (sys_rst),
        .wbRsp_i (wbRsp_i),
        .xo_i    (xo_i),
        .wbReq_o (wbReq_o),
        .pif_o   (pif_o)
    );

    always #50 xclk = ~xclk;

    // random byte from bits 23:16 of the LCG state
    function automatic logic [7:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[23:16];
    endfunction

    // expected port value after one received byte or one transmit
    function automatic pifPort_t predictPort(input pifPort_t cur, input logic isTx,
                                             input logic [7:0] b);
        pifPort_t nxt;
        nxt            = cur;
        nxt.pWr        = 1'b0;
        nxt.rdFinished = 1'b0;
        if (isTx) begin
            nxt.rdFinished = 1'b1;
        end else if (b[7:6] == `PIF_TAG_ADDR) begin
            nxt.rwAddr = b[`PIF_ADDR_W-1:0];
            nxt.rdSubA = '0;
        end else if (b[7:6] == `PIF_TAG_DATA) begin
            nxt.pWr    = 1'b1;
            nxt.wrData = b[`PIF_DATA_BITS-1:0];
        end
        return nxt;
    endfunction

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWbReq(input string name, input wbReq_t exp, input wbReq_t act);
        wbReq_t seen;
        seen = act;
        // read data lines carry nothing
        if (!exp.we) begin
            seen.dat = exp.dat;
        end
        if (seen !== exp) begin
            stopRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkPif(input string name, input pifPort_t exp, input pifPort_t act);
        if (act !== exp) begin
            stopRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // ------------------------------
    // scenario building
    // ------------------------------

    task automatic pushXfer(input string name, input logic we, input logic [7:0] adr,
                            input logic [7:0] dat);
        expXfer.push_back({1'b1, 1'b1, we, adr, dat});
        xferName.push_back(name);
        stallQ.push_back(nextRand() % 4);
    endtask

    task automatic pushSr(input string name, input logic [7:0] sr);
        srQ.push_back(sr);
        pushXfer(name, 1'b0, `PIF_I2C_SR, 8'h00);
    endtask

    task automatic pushRx(input string name, input logic [7:0] b);
        rxQ.push_back(b);
        pushXfer(name, 1'b0, `PIF_I2C_RXDR, 8'h00);
    endtask

    task automatic trackPort(input string name, input logic isTx, input logic [7:0] b);
        pifPort_t exp;
        exp = predictPort(refState, isTx, b);
        if (exp.pWr || exp.rdFinished) begin
            expPif.push_back(exp);
            pifName.push_back(name);
        end
        refState = exp;
        // read-finished shows the old sub-address, then it counts on
        refState.rdSubA = exp.rdSubA + exp.rdFinished;
    endtask

    task automatic scriptInit(input string name, input int nBusy);
        pushXfer(name, 1'b1, `PIF_I2C_CMDR, `PIF_CMD_CKSDIS);
        repeat (nBusy) pushSr(name, srBusy);
        pushSr(name, srIdle);
        // flushed bytes carry tags so a leak would show on the port
        pushRx(name, 8'h83);
        pushRx(name, 8'h5a);
        pushXfer(name, 1'b1, `PIF_I2C_CMDR, `PIF_CMD_RUN);
    endtask

    // idle polls, busy, then the status that decides
    task automatic scriptPoll(input string name, input logic [7:0] decide);
        repeat (nextRand() % 3) pushSr(name, srIdle);
        pushSr(name, srBusy);
        pushSr(name, decide);
    endtask

    task automatic scriptRx(input string name, input logic [7:0] b);
        scriptPoll(name, srRx);
        pushRx(name, b);
        trackPort(name, 1'b0, b);
    endtask

    task automatic scriptTx(input string name, input logic [7:0] v);
        scriptPoll(name, srTx);
        xoQ.push_back(v);
        pushXfer(name, 1'b1, `PIF_I2C_TXDR, v);
        trackPort(name, 1'b1, 8'h00);
    endtask

    // ------------------------------
    // controller model
    // ------------------------------

    task automatic serveXfer(input wbReq_t act);
        logic [7:0] rdData;
        rdData = 8'h00;
        if (!act.we && act.adr == `PIF_I2C_SR && srQ.size() > 0) begin
            rdData = srQ.pop_front();
        end else if (!act.we && act.adr == `PIF_I2C_RXDR && rxQ.size() > 0) begin
            rdData = rxQ.pop_front();
        end else if (act.we && act.adr == `PIF_I2C_TXDR && xoQ.size() > 0) begin
            xoQ.delete(0);
        end
        // past the end of the script the DUT only polls SR
        if (expXfer.size() > 0) begin
            checkWbReq(xferName.pop_front(), expXfer.pop_front(), act);
        end
        wbRsp_i.ack <= 1'b1;
        wbRsp_i.dat <= rdData;
    endtask

    always @(posedge xclk) begin
        if (sys_rst) begin
            wbRsp_i.ack <= 1'b0;
            if (wbReq_o.cyc && wbReq_o.stb && !wbRsp_i.ack) begin
                if (!xferOpen) begin
                    xferOpen  = 1'b1;
                    stallLeft = 0;
                    if (stallQ.size() > 0) begin
                        stallLeft = stallQ.pop_front();
                    end
                end
                if (stallLeft > 0) begin
                    stallLeft = stallLeft - 1;
                end else begin
                    xferOpen = 1'b0;
                    serveXfer(wbReq_o);
                end
            end
        end
        // next byte to transmit waits on xo_i
        xo_i <= (xoQ.size() > 0) ? xoQ[0] : 8'h00;
    end

    // port pulses against the predicted stream
    always @(posedge xclk) begin
        if (sys_rst && (pif_o.pWr || pif_o.rdFinished)) begin
            if (expPif.size() == 0) begin
                stopRun("port pulse seen with no event left to explain it");
            end else begin
                checkPif(pifName.pop_front(), expPif.pop_front(), pif_o);
            end
        end
    end

    initial begin : mainSeq
        logic [7:0] rnd;
        int         n;
        int         waitCnt;
        xclk      = 1'b0;
        sys_rst   = 1'b0;
        wbRsp_i   = '0;
        xo_i      = 8'h00;
        xferOpen  = 1'b0;
        stallLeft = 0;
        refState  = '0;
        lcgState  = 32'd18;

        scriptInit("init", 3);
        scriptRx("addr", {`PIF_TAG_ADDR, 6'h25});
        for (n = 0; n < 8; n++) begin
            rnd = nextRand();
            scriptRx("write", {`PIF_TAG_DATA, rnd[5:0]});
        end
        // tags 00 and 11 change nothing so address 5 stays
        scriptRx("tag00", 8'h2c);
        scriptRx("tag11", 8'hf3);
        scriptRx("writeAfterTags", {`PIF_TAG_DATA, 6'h15});
        scriptRx("addrTx", {`PIF_TAG_ADDR, 6'h3a});
        // enough transmits to wrap the sub-address
        for (n = 0; n < 130; n++) begin
            scriptTx("tx", nextRand());
        end
        scriptRx("addrAgain", {`PIF_TAG_ADDR, 6'h07});
        scriptTx("txAfterAddr", nextRand());
        scriptPoll("nak", srNak);
        scriptInit("nakRestart", 0);
        scriptPoll("busyDrop", srIdle);
        scriptInit("dropRestart", 1);
        scriptRx("lastWrite", {`PIF_TAG_DATA, 6'h2a});

        repeat (2) @(posedge xclk);
        checkWbReq("reset", '0, wbReq_o);
        checkPif("reset", '0, pif_o);
        sys_rst <= 1'b1;

        waitCnt = 0;
        while ((expXfer.size() > 0 || expPif.size() > 0) && waitCnt < drainLimit) begin
            @(posedge xclk);
            waitCnt++;
        end
        if (waitCnt >= drainLimit) begin
            stopRun("timeout while waiting for the scripted transfers and port pulses");
        end else begin
            // room for a stray pulse to show up
            repeat (8) @(posedge xclk);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+common
common/pifwb_pkg.sv
hdl/efbRespDecode.sv
wbSequencer/wbSequencer.sv
hdl/pifPortStage.sv
hdl/pifWbBridge.sv
dv/pifwb_checker.sv
dv/pifwb_tb.sv

//--- Bender.yml
package:
  name: pifwb

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pifwb_pkg.sv
      - hdl/efbRespDecode.sv
      - wbSequencer/wbSequencer.sv
      - hdl/pifPortStage.sv
      - hdl/pifWbBridge.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/pifwb_checker.sv
      - dv/pifwb_tb.sv
